//--- Bender.yml
package:
  name: alu_lane

sources:
  # Packages first
  - common/isa_pkg.sv
  - common/pipe_pkg.sv
  # Design
  - verilog/wb_select.sv
  - alu/ma_unit.sv
  - alu/div_unit.sv
  - alu/cnvt_unit.sv
  - alu/srl_unit.sv
  - alu/alu.sv
  # Testbench
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_alu.sv

//--- alu/alu.sv
`timescale 1ns/1ps

module alu (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					req,
	input	logic					stall,
	input	isa_pkg::op_type_t		op_type,
	input	isa_pkg::op_class_t		op_class,
	input	isa_pkg::op_fn_t		op_fn,
	input	isa_pkg::reg_addr_t		dst,
	input	pipe_pkg::issue_no_t	cmd_issue_no,
	input	isa_pkg::data_t			src1,
	input	isa_pkg::data_t			src2,
	input	isa_pkg::src3_u			src3,
	input	pipe_pkg::issue_no_t	issue_no,		// Issuer's running count
	input	logic					wb_ready,
	output	logic					accept,
	output	logic					wb_done,
	output	isa_pkg::reg_addr_t		wb_dst,
	output	pipe_pkg::issue_no_t	wb_issue_no,
	output	isa_pkg::data_t			wb_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic			is_arith;
	logic			is_shift;
	logic			tgt_ma;
	logic			tgt_div;
	logic			tgt_cnvt;
	logic			tgt_srl;
	logic			tgt_none;
	logic			tgt_ready;

	logic			en_ma;
	logic			en_div;
	logic			en_cnvt;
	logic			en_srl;

	wb_token_t		tok_in;
	wb_token_t		tok_ma_in;
	wb_token_t		tok_div_in;
	wb_token_t		tok_cnvt_in;
	wb_token_t		tok_srl_in;

	data_t			ma_src1;
	data_t			ma_src2;
	src3_u			ma_src3;
	data_t			div_src1;
	data_t			div_src2;
	data_t			cnvt_src1;
	data_t			srl_src1;
	src3_u			srl_src3;

	logic			rdy_ma;
	logic			rdy_div;
	logic			rdy_cnvt;
	logic			rdy_srl;
	logic			vld_ma;
	logic			vld_div;
	logic			vld_cnvt;
	logic			vld_srl;
	data_t			dat_ma;
	data_t			dat_div;
	data_t			dat_cnvt;
	data_t			dat_srl;
	wb_token_t		tok_ma;
	wb_token_t		tok_div;
	wb_token_t		tok_cnvt;
	wb_token_t		tok_srl;
	logic			gnt_ma;
	logic			gnt_div;
	logic			gnt_cnvt;
	logic			gnt_srl;

	unit_sel_t		sel;
	wb_token_t		tok_sel;

	////////////////////////////////////////////////////////////
	// Decode and dispatch

	assign is_arith		= (op_type == OPT_ARITH);
	assign is_shift		= (op_type == OPT_SHIFT);

	assign tgt_ma		= is_arith & ((op_class == CLS_ADD) | (op_class == CLS_MUL));
	assign tgt_div		= is_arith & (op_class == CLS_DIV);
	assign tgt_cnvt		= is_arith & (op_class == CLS_CNVT);
	assign tgt_srl		= is_shift;
	assign tgt_none		= ~is_arith & ~is_shift;	// Taken and dropped

	assign tgt_ready	= (tgt_ma & rdy_ma) | (tgt_div & rdy_div) |
						  (tgt_cnvt & rdy_cnvt) | (tgt_srl & rdy_srl) | tgt_none;

	assign accept		= req & ~stall & tgt_ready;

	assign en_ma		= accept & tgt_ma;
	assign en_div		= accept & tgt_div;
	assign en_cnvt		= accept & tgt_cnvt;
	assign en_srl		= accept & tgt_srl;

	assign tok_in		= '{v: 1'b1, op_type: op_type, op_class: op_class, op_fn: op_fn,
							dst: dst, issue_no: cmd_issue_no};

	// Idle units see all zeros
	assign tok_ma_in	= en_ma   ? tok_in : '0;
	assign tok_div_in	= en_div  ? tok_in : '0;
	assign tok_cnvt_in	= en_cnvt ? tok_in : '0;
	assign tok_srl_in	= en_srl  ? tok_in : '0;

	assign ma_src1		= en_ma   ? src1 : '0;
	assign ma_src2		= en_ma   ? src2 : '0;
	assign ma_src3		= en_ma   ? src3 : '0;
	assign div_src1		= en_div  ? src1 : '0;
	assign div_src2		= en_div  ? src2 : '0;
	assign cnvt_src1	= en_cnvt ? src1 : '0;
	assign srl_src1		= en_srl  ? src1 : '0;
	assign srl_src3		= en_srl  ? src3 : '0;

	////////////////////////////////////////////////////////////
	// Write-back

	always_comb begin
		case (sel)
			UNIT_MA: begin
				tok_sel	= tok_ma;
				wb_data	= dat_ma;
			end
			UNIT_DIV: begin
				tok_sel	= tok_div;
				wb_data	= dat_div;
			end
			UNIT_CNVT: begin
				tok_sel	= tok_cnvt;
				wb_data	= dat_cnvt;
			end
			default: begin
				tok_sel	= tok_srl;
				wb_data	= dat_srl;
			end
		endcase
	end

	assign wb_dst		= tok_sel.dst;
	assign wb_issue_no	= tok_sel.issue_no;

	ma_unit u_ma (
		.clock(clock), .rst_n(rst_n), .en(en_ma), .op_fn(tok_ma_in.op_fn),
		.src1(ma_src1), .src2(ma_src2), .src3(ma_src3), .token(tok_ma_in),
		.grant(gnt_ma), .ready(rdy_ma), .valid(vld_ma), .data(dat_ma), .token_out(tok_ma)
	);

	div_unit u_div (
		.clock(clock), .rst_n(rst_n), .en(en_div), .op_fn(tok_div_in.op_fn),
		.src1(div_src1), .src2(div_src2), .token(tok_div_in),
		.grant(gnt_div), .ready(rdy_div), .valid(vld_div), .data(dat_div), .token_out(tok_div)
	);

	cnvt_unit u_cnvt (
		.clock(clock), .rst_n(rst_n), .en(en_cnvt), .op_fn(tok_cnvt_in.op_fn),
		.src1(cnvt_src1), .token(tok_cnvt_in), .grant(gnt_cnvt),
		.ready(rdy_cnvt), .valid(vld_cnvt), .data(dat_cnvt), .token_out(tok_cnvt)
	);

	srl_unit u_srl (
		.clock(clock), .rst_n(rst_n), .en(en_srl), .src1(srl_src1), .src3(srl_src3),
		.token(tok_srl_in), .grant(gnt_srl),
		.ready(rdy_srl), .valid(vld_srl), .data(dat_srl), .token_out(tok_srl)
	);

	wb_select u_wb_select (
		.issue_no(issue_no),
		.valid_ma(vld_ma), .valid_div(vld_div), .valid_cnvt(vld_cnvt), .valid_srl(vld_srl),
		.issue_ma(tok_ma.issue_no), .issue_div(tok_div.issue_no),
		.issue_cnvt(tok_cnvt.issue_no), .issue_srl(tok_srl.issue_no),
		.wb_ready(wb_ready), .sel(sel), .done(wb_done),
		.grant_ma(gnt_ma), .grant_div(gnt_div), .grant_cnvt(gnt_cnvt), .grant_srl(gnt_srl)
	);

	// A command goes to exactly one unit
	assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0({en_ma, en_div, en_cnvt, en_srl}))
		else $error("alu: several unit enables in one cycle");

endmodule

//--- alu/cnvt_unit.sv
`timescale 1ns/1ps

module cnvt_unit (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					en,
	input	isa_pkg::op_fn_t		op_fn,
	input	isa_pkg::data_t			src1,
	input	pipe_pkg::wb_token_t	token,
	input	logic					grant,
	output	logic					ready,
	output	logic					valid,
	output	isa_pkg::data_t			data,
	output	pipe_pkg::wb_token_t	token_out
);
	import isa_pkg::*;

	logic			neg;
	data_t			mag;
	logic [4:0]		lead;			// Leading one position
	data_t			norm;
	logic [7:0]		expo;
	data_t			flt;
	logic			vld;

	assign neg	= (op_fn == I2F) & src1[31];
	assign mag	= neg ? (~src1 + 32'd1) : src1;

	always_comb begin
		lead = '0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				lead = 5'(i);
			end
		end
	end

	assign norm	= mag << (5'd31 - lead);	// Hidden bit lands in bit 31
	assign expo	= 8'd127 + {3'b000, lead};
	// Low bits past the mantissa are just dropped
	assign flt	= (mag == '0) ? '0 : {neg, expo, norm[30:8]};

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			vld <= 1'b0;
		end else if (en) begin
			vld <= 1'b1;
		end else if (grant) begin
			vld <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (en) begin
			data		<= flt;
			token_out	<= token;
		end
	end

	assign valid	= vld;
	assign ready	= ~vld;		// Holds one result

endmodule

//--- alu/div_unit.sv
`timescale 1ns/1ps

module div_unit (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					en,
	input	isa_pkg::op_fn_t		op_fn,
	input	isa_pkg::data_t			src1,		// Dividend
	input	isa_pkg::data_t			src2,		// Divisor
	input	pipe_pkg::wb_token_t	token,
	input	logic					grant,
	output	logic					ready,
	output	logic					valid,
	output	isa_pkg::data_t			data,
	output	pipe_pkg::wb_token_t	token_out
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic					busy;
	logic					vld;
	logic [DIV_CNT_W-1:0]	cnt;
	op_fn_t					fn;
	data_t					q;			// Dividend shifts out, quotient shifts in
	data_t					r;			// Partial remainder
	data_t					d;
	logic [32:0]			r_sh;
	logic [32:0]			diff;
	logic					ge;

	assign r_sh	= {r, q[31]};
	assign diff	= r_sh - {1'b0, d};
	assign ge	= (r_sh >= {1'b0, d});	// Zero divisor always subtracts

	////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			busy	<= 1'b0;
			vld		<= 1'b0;
			cnt		<= '0;
		end else if (en) begin
			busy	<= 1'b1;
			cnt		<= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (cnt == DIV_CNT_W'(DIV_CYCLES - 1)) begin
				busy	<= 1'b0;
				vld		<= 1'b1;
			end
		end else if (vld & grant) begin
			vld <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Restoring iteration

	always_ff @(posedge clock) begin
		if (en) begin
			q			<= src1;
			r			<= '0;
			d			<= src2;
			fn			<= op_fn;
			token_out	<= token;
		end else if (busy) begin
			if (ge) begin
				r <= diff[31:0];
				q <= {q[30:0], 1'b1};
			end else begin
				r <= r_sh[31:0];	// Restore
				q <= {q[30:0], 1'b0};
			end
		end
	end

	assign data		= (fn == REMU) ? r : q;
	assign valid	= vld;
	assign ready	= ~busy & ~vld;		// One divide at a time

	// Dispatch must wait for the previous result to leave
	assert property (@(posedge clock) disable iff (!rst_n)
		en |-> (!busy && !vld))
		else $error("div_unit: enable while busy");

endmodule

//--- alu/ma_unit.sv
`timescale 1ns/1ps

module ma_unit (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					en,
	input	isa_pkg::op_fn_t		op_fn,
	input	isa_pkg::data_t			src1,
	input	isa_pkg::data_t			src2,
	input	isa_pkg::src3_u			src3,
	input	pipe_pkg::wb_token_t	token,
	input	logic					grant,
	output	logic					ready,
	output	logic					valid,
	output	isa_pkg::data_t			data,
	output	pipe_pkg::wb_token_t	token_out
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic					adv;			// Whole pipe moves
	logic [MA_DEPTH-1:0]	vld;
	wb_token_t				tk [MA_DEPTH];

	op_fn_t					fn0;
	op_fn_t					fn1;
	data_t					a0;
	data_t					b0;
	data_t					c0;
	data_t					a1;
	data_t					b1;
	data_t					c1;
	logic [47:0]			pl_full;
	logic [31:0]			ph_full;
	data_t					pp_lo;			// a * b[15:0]
	logic [15:0]			pp_hi;			// Upper partial, low half only
	data_t					prod;
	logic					mul1;
	data_t					x2;
	data_t					y2;

	assign adv		= ~(vld[MA_DEPTH-1] & ~grant);
	assign ready	= adv;

	assign pl_full	= a0 * b0[15:0];
	assign ph_full	= a0[15:0] * b0[31:16];
	assign prod		= pp_lo + {pp_hi, 16'h0000};
	assign mul1		= (tk[1].op_class == CLS_MUL);	// Add class bypasses the product

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			vld <= '0;
		end else if (adv) begin
			vld <= {vld[MA_DEPTH-2:0], en};
		end
	end

	always_ff @(posedge clock) begin
		if (adv) begin
			tk[0]	<= token;
			for (int i = 1; i < MA_DEPTH; i++) begin
				tk[i] <= tk[i-1];
			end
			// Operand capture
			fn0		<= op_fn;
			a0		<= src1;
			b0		<= src2;
			c0		<= src3.addend;
			// Partial products
			fn1		<= fn0;
			a1		<= a0;
			b1		<= b0;
			c1		<= c0;
			pp_lo	<= pl_full[31:0];
			pp_hi	<= ph_full[15:0];
			// Combine, pick adder inputs
			x2		<= mul1 ? prod : a1;
			if (mul1) begin
				y2 <= (fn1 == MADD) ? c1 : '0;
			end else begin
				y2 <= (fn1 == SUB) ? (~b1 + 32'd1) : b1;
			end
			data	<= x2 + y2;				// Final add stage
		end
	end

	assign valid		= vld[MA_DEPTH-1];
	assign token_out	= tk[MA_DEPTH-1];

endmodule

//--- alu/srl_unit.sv
`timescale 1ns/1ps

module srl_unit (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					en,
	input	isa_pkg::data_t			src1,
	input	isa_pkg::src3_u			src3,		// Read as shift control
	input	pipe_pkg::wb_token_t	token,
	input	logic					grant,
	output	logic					ready,
	output	logic					valid,
	output	isa_pkg::data_t			data,
	output	pipe_pkg::wb_token_t	token_out
);
	import isa_pkg::*;

	shift_mode_t	mode;
	logic [4:0]		amt;
	logic [63:0]	dbl;
	data_t			res;
	logic			vld;

	assign mode	= src3.shift.mode;
	assign amt	= src3.shift.amt;
	assign dbl	= {src1, src1} << amt;		// Upper half is the rotate

	always_comb begin
		case (mode)
			SLL:		res = src1 << amt;
			SRL:		res = src1 >> amt;
			SRA:		res = $signed(src1) >>> amt;
			default:	res = dbl[63:32];
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			vld <= 1'b0;
		end else if (en) begin
			vld <= 1'b1;
		end else if (grant) begin
			vld <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (en) begin
			data		<= res;
			token_out	<= token;
		end
	end

	assign valid	= vld;
	assign ready	= ~vld;

endmodule

//--- common/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0]	data_t;			// Operand or result word
	typedef logic [4:0]		reg_addr_t;		// Destination register

	////////////////////////////////////////////////////////////
	// Command fields

	typedef logic [1:0]		op_type_t;
	typedef logic [1:0]		op_class_t;		// Arithmetic only
	typedef logic [1:0]		op_fn_t;

	localparam op_type_t	OPT_ARITH	= 2'b00;
	localparam op_type_t	OPT_SHIFT	= 2'b10;

	localparam op_class_t	CLS_ADD		= 2'b00;
	localparam op_class_t	CLS_MUL		= 2'b01;
	localparam op_class_t	CLS_DIV		= 2'b10;
	localparam op_class_t	CLS_CNVT	= 2'b11;

	// Variant within a class
	localparam op_fn_t		ADD			= 2'b00;
	localparam op_fn_t		SUB			= 2'b01;
	localparam op_fn_t		MUL			= 2'b00;	// Low word of product
	localparam op_fn_t		MADD		= 2'b01;	// Product plus third word
	localparam op_fn_t		DIVU		= 2'b00;
	localparam op_fn_t		REMU		= 2'b01;
	localparam op_fn_t		I2F			= 2'b00;	// Signed source
	localparam op_fn_t		U2F			= 2'b01;

	////////////////////////////////////////////////////////////
	// Third source word

	typedef logic [1:0]		shift_mode_t;

	localparam shift_mode_t	SLL			= 2'b00;
	localparam shift_mode_t	SRL			= 2'b01;
	localparam shift_mode_t	SRA			= 2'b10;
	localparam shift_mode_t	ROL			= 2'b11;

	typedef struct packed {
		logic [24:0]		pad;
		shift_mode_t		mode;
		logic [4:0]			amt;
	} shift_ctl_t;

	typedef union packed {
		data_t				addend;			// Multiply-add
		shift_ctl_t			shift;			// Shift/rotate
	} src3_u;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

	typedef logic [7:0]		issue_no_t;		// Wraps at 256

	// Travels with a command from dispatch to write-back
	typedef struct packed {
		logic					v;
		isa_pkg::op_type_t		op_type;
		isa_pkg::op_class_t		op_class;
		isa_pkg::op_fn_t		op_fn;
		isa_pkg::reg_addr_t		dst;
		issue_no_t				issue_no;
	} wb_token_t;

	////////////////////////////////////////////////////////////
	// Execution units

	typedef enum logic [1:0] {
		UNIT_MA		= 2'd0,
		UNIT_DIV	= 2'd1,
		UNIT_CNVT	= 2'd2,
		UNIT_SRL	= 2'd3
	} unit_sel_t;

	localparam int MA_DEPTH		= 4;		// Three multiply stages and one add
	localparam int DIV_CYCLES	= 32;		// One quotient bit per cycle
	localparam int DIV_CNT_W	= $clog2(DIV_CYCLES);

endpackage

//--- testbench/tb_alu.sv
`timescale 1ns/1ps

module tb_alu;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int N_CMDS	= 51;		// 16 MA, 6 DIV, 10 CNVT, 10 SRL, 1 dropped, 8 mixed
	localparam int TIMEOUT	= N_CMDS * 40 + 200;

	logic		clock;
	logic		rst_n;
	logic		req;
	logic		stall;
	op_type_t	op_type;
	op_class_t	op_class;
	op_fn_t		op_fn;
	reg_addr_t	dst;
	issue_no_t	cmd_issue_no;
	data_t		src1;
	data_t		src2;
	src3_u		src3;
	issue_no_t	issue_no;
	logic		wb_ready;
	logic		accept;
	logic		wb_done;
	reg_addr_t	wb_dst;
	issue_no_t	wb_issue_no;
	data_t		wb_data;

	integer		seed;
	int			cycles;
	int			data_errs;
	int			dst_errs;
	int			other_errs;
	int			n_exp;
	int			n_ret;
	data_t		exp_data [256];
	reg_addr_t	exp_dst [256];
	logic		pending [256];
	logic		is_div [256];
	logic		held [256];			// Waiting when wb_ready went high
	logic		div_out;
	issue_no_t	drain_base;
	issue_no_t	mon_no;
	issue_no_t	off;
	issue_no_t	last_off;
	logic		seen_held;

	tb_clock u_clock (.clock(clock), .rst_n(rst_n));

	alu dut (
		.clock(clock), .rst_n(rst_n), .req(req), .stall(stall), .op_type(op_type),
		.op_class(op_class), .op_fn(op_fn), .dst(dst), .cmd_issue_no(cmd_issue_no),
		.src1(src1), .src2(src2), .src3(src3), .issue_no(issue_no), .wb_ready(wb_ready),
		.accept(accept), .wb_done(wb_done), .wb_dst(wb_dst), .wb_issue_no(wb_issue_no),
		.wb_data(wb_data)
	);

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic data_t int_to_float(data_t v, logic signed_src);
		logic	neg;
		data_t	mag;
		data_t	man;
		int		msb;
		neg = signed_src & v[31];
		mag = neg ? (32'd0 - v) : v;
		if (mag == 32'd0)
			return 32'd0;
		msb = 31;
		while (!mag[msb])
			msb--;
		if (msb > 23)
			man = mag >> (msb - 23);		// Truncate toward zero
		else
			man = mag << (23 - msb);
		return {neg, 8'(127 + msb), man[22:0]};
	endfunction

	function automatic data_t shift_model(data_t a, src3_u ctl);
		data_t r;
		r = a;
		case (ctl.shift.mode)
			SLL: r = a << ctl.shift.amt;
			SRL: r = a >> ctl.shift.amt;
			SRA: for (int i = 0; i < ctl.shift.amt; i++) r = {r[31], r[31:1]};
			default: for (int i = 0; i < ctl.shift.amt; i++) r = {r[30:0], r[31]};
		endcase
		return r;
	endfunction

	function automatic data_t alu_model(op_type_t t, op_class_t c, op_fn_t f, data_t a,
			data_t b, src3_u s3);
		if (t == OPT_SHIFT)
			return shift_model(a, s3);
		case (c)
			CLS_ADD: return (f == SUB) ? a - b : a + b;
			CLS_MUL: return (f == MADD) ? a * b + s3.addend : a * b;
			CLS_DIV: begin
				if (b == 32'd0)
					return (f == REMU) ? a : 32'hffff_ffff;
				return (f == REMU) ? a % b : a / b;
			end
			default: return int_to_float(a, f == I2F);
		endcase
	endfunction

	function automatic data_t shift_word(shift_mode_t m, logic [4:0] amt);
		src3_u w;
		w.shift.pad		= 25'($random(seed));	// Must be ignored
		w.shift.mode	= m;
		w.shift.amt		= amt;
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_data(input data_t got, input data_t exp, input string name);
		if (got !== exp) begin
			data_errs++;
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_dst(input reg_addr_t got, input reg_addr_t exp, input string name);
		if (got !== exp) begin
			dst_errs++;
			$display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Issue side

	task automatic drive_cmd(input op_type_t t, input op_class_t c, input op_fn_t f,
			input data_t a, input data_t b, input data_t s3);
		integer rnd;
		rnd				= $random(seed);
		req				= 1'b1;
		op_type			= t;
		op_class		= c;
		op_fn			= f;
		dst				= rnd[4:0];
		cmd_issue_no	= issue_no;
		src1			= a;
		src2			= b;
		src3			= s3;
	endtask

	task automatic wait_accept;
		logic div_cmd;
		@(negedge clock);
		while (!accept)
			@(negedge clock);
		if (op_type == OPT_ARITH || op_type == OPT_SHIFT) begin
			div_cmd = (op_type == OPT_ARITH) && (op_class == CLS_DIV);
			if (div_cmd && div_out) begin
				other_errs++;
				$display("t=%0t: second divide accepted before the first wrote back", $time);
			end
			exp_data[issue_no]	= alu_model(op_type, op_class, op_fn, src1, src2, src3);
			exp_dst[issue_no]	= dst;
			is_div[issue_no]	= div_cmd;
			pending[issue_no]	= 1'b1;
			div_out				= div_out | div_cmd;
			n_exp++;
		end
		@(posedge clock);
		#10;
		issue_no	= issue_no + 8'd1;
		req			= 1'b0;
		stall		= 1'b0;
	endtask

	task automatic issue(input op_type_t t, input op_class_t c, input op_fn_t f,
			input data_t a, input data_t b, input data_t s3, input int hold);
		drive_cmd(t, c, f, a, b, s3);
		if (hold > 0) begin
			stall = 1'b1;
			repeat (hold) begin
				@(negedge clock);
				if (accept) begin
					other_errs++;
					$display("t=%0t: command accepted while stall was high", $time);
				end
			end
			@(posedge clock);
			#10 stall = 1'b0;
		end
		wait_accept();
	endtask

	////////////////////////////////////////////////////////////
	// Write-back monitor

	always @(negedge clock) begin
		if (rst_n && wb_done && wb_ready) begin
			mon_no = wb_issue_no;
			if (!pending[mon_no]) begin
				other_errs++;
				$display("t=%0t: write-back for issue number %0d that is not outstanding",
					$time, mon_no);
			end else begin
				check_data(wb_data, exp_data[mon_no], "wb_data");
				check_dst(wb_dst, exp_dst[mon_no], "wb_dst");
				pending[mon_no] = 1'b0;
				if (is_div[mon_no])
					div_out = 1'b0;
				n_ret++;
			end
			if (held[mon_no]) begin
				off = mon_no - drain_base;
				if (seen_held && off <= last_off) begin
					other_errs++;
					$display("t=%0t: held result %0d drained after a younger one", $time, mon_no);
				end
				seen_held		= 1'b1;
				last_off		= off;
				held[mon_no]	= 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("t=%0t: timeout after %0d cycles with %0d results missing",
				$time, cycles, n_exp - n_ret);
			$display("errors: data %0d, dst %0d, other %0d", data_errs, dst_errs, other_errs);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		seed = 65532;
		req = 1'b0;
		stall = 1'b0;
		op_type = OPT_ARITH;
		op_class = CLS_ADD;
		op_fn = ADD;
		dst = '0;
		cmd_issue_no = '0;
		src1 = '0;
		src2 = '0;
		src3 = '0;
		issue_no = '0;
		wb_ready = 1'b1;
		cycles = 0;
		data_errs = 0;
		dst_errs = 0;
		other_errs = 0;
		n_exp = 0;
		n_ret = 0;
		div_out = 1'b0;
		seen_held = 1'b0;
		drain_base = '0;
		last_off = '0;
		for (int n = 0; n < 256; n++) begin
			pending[n] = 1'b0;
			held[n] = 1'b0;
			is_div[n] = 1'b0;
		end

		@(posedge rst_n);
		@(negedge clock);
		if (wb_done) begin
			other_errs++;
			$display("t=%0t: wb_done high right after reset", $time);
		end
		@(posedge clock);
		#10;

		// Add, subtract, multiply, multiply-add; one held off by stall
		for (int i = 0; i < 16; i++)
			issue(OPT_ARITH, (i % 4 >= 2) ? CLS_MUL : CLS_ADD, op_fn_t'(i % 2),
				$random(seed), $random(seed), $random(seed), (i == 5) ? 3 : 0);

		// Back-to-back divides wait on each other
		issue(OPT_ARITH, CLS_DIV, DIVU, 32'd100, 32'd7, '0, 0);
		issue(OPT_ARITH, CLS_DIV, REMU, 32'd100, 32'd7, '0, 0);
		issue(OPT_ARITH, CLS_DIV, DIVU, 32'd5, 32'd9, '0, 0);
		issue(OPT_ARITH, CLS_DIV, DIVU, $random(seed), 32'd0, '0, 0);
		issue(OPT_ARITH, CLS_DIV, REMU, $random(seed), 32'd0, '0, 0);
		issue(OPT_ARITH, CLS_DIV, REMU, 32'hffff_ffff, 32'd3, '0, 0);

		issue(OPT_ARITH, CLS_CNVT, I2F, 32'd0, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, U2F, 32'd0, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, I2F, 32'hffff_ffff, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, I2F, 32'hffff_fffb, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, I2F, 32'h8000_0000, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, U2F, 32'h8000_0000, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, U2F, 32'h0010_0000, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, U2F, 32'hffff_ffff, '0, '0, 0);	// Loses low bits
		issue(OPT_ARITH, CLS_CNVT, I2F, 32'h0123_4567, '0, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, I2F, 32'h0000_0010, '0, '0, 0);

		for (int m = 0; m < 4; m++)
			for (int k = 0; k < 2; k++)
				issue(OPT_SHIFT, CLS_ADD, ADD, $random(seed), '0,
					shift_word(shift_mode_t'(m), (k == 1) ? 5'd31 : 5'd0), 0);
		issue(OPT_SHIFT, CLS_ADD, ADD, $random(seed), '0, shift_word(SRA, 5'd7), 0);
		issue(OPT_SHIFT, CLS_ADD, ADD, $random(seed), '0, shift_word(ROL, 5'd13), 0);

		issue(2'b01, CLS_ADD, ADD, 32'd1, 32'd2, '0, 0);	// Dropped, no write-back

		// Fill every unit with write-back blocked
		while (n_ret != n_exp)
			@(posedge clock);
		#10;
		wb_ready	= 1'b0;
		drain_base	= issue_no;
		issue(OPT_ARITH, CLS_DIV, DIVU, $random(seed), 32'd13, '0, 0);
		issue(OPT_ARITH, CLS_CNVT, I2F, $random(seed), '0, '0, 0);
		issue(OPT_SHIFT, CLS_ADD, ADD, $random(seed), '0, shift_word(SRL, 5'd4), 0);
		for (int i = 0; i < 4; i++)
			issue(OPT_ARITH, CLS_MUL, MADD, $random(seed), $random(seed), $random(seed), 0);
		drive_cmd(OPT_ARITH, CLS_CNVT, U2F, $random(seed), '0, '0);
		repeat (40) begin
			@(negedge clock);
			if (accept) begin
				other_errs++;
				$display("t=%0t: convert accepted while its unit holds a result", $time);
			end
		end
		@(posedge clock);
		#10;
		for (int n = 0; n < 256; n++)
			held[n] = pending[n];
		wb_ready = 1'b1;
		wait_accept();

		while (n_ret != n_exp)
			@(posedge clock);
		repeat (5) @(posedge clock);	// Catch stray write-backs

		$display("errors: data %0d, dst %0d, other %0d", data_errs, dst_errs, other_errs);
		if (data_errs + dst_errs + other_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output	logic	clock,
	output	logic	rst_n
);
	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;		// 100 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clock);
		#10 rst_n = 1'b1;
	end

endmodule

//--- verilog/wb_select.sv
`timescale 1ns/1ps

module wb_select (
	input	pipe_pkg::issue_no_t	issue_no,
	input	logic					valid_ma,
	input	logic					valid_div,
	input	logic					valid_cnvt,
	input	logic					valid_srl,
	input	pipe_pkg::issue_no_t	issue_ma,
	input	pipe_pkg::issue_no_t	issue_div,
	input	pipe_pkg::issue_no_t	issue_cnvt,
	input	pipe_pkg::issue_no_t	issue_srl,
	input	logic					wb_ready,
	output	pipe_pkg::unit_sel_t	sel,
	output	logic					done,
	output	logic					grant_ma,
	output	logic					grant_div,
	output	logic					grant_cnvt,
	output	logic					grant_srl
);
	import pipe_pkg::*;

	logic [3:0]		vld;
	issue_no_t		age [4];
	issue_no_t		best;
	logic			found;
	logic [3:0]		grant;

	assign vld		= {valid_srl, valid_cnvt, valid_div, valid_ma};

	// Age wraps with the issue count
	assign age[0]	= issue_no - issue_ma;
	assign age[1]	= issue_no - issue_div;
	assign age[2]	= issue_no - issue_cnvt;
	assign age[3]	= issue_no - issue_srl;

	always_comb begin
		sel		= UNIT_MA;
		best	= '0;
		found	= 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (vld[i] && (!found || (age[i] > best))) begin	// Strict, so ties stay low
				sel		= unit_sel_t'(i);
				best	= age[i];
				found	= 1'b1;
			end
		end
	end

	assign done			= |vld;
	assign grant		= (done & wb_ready) ? (4'b0001 << sel) : 4'b0000;

	assign grant_ma		= grant[0];
	assign grant_div	= grant[1];
	assign grant_cnvt	= grant[2];
	assign grant_srl	= grant[3];

	always_comb begin
		assert final ($onehot0(grant) && ((grant & ~vld) == 4'b0000))
			else $error("wb_select: grant not one-hot to a valid unit");
	end

endmodule

//--- vlog.f
common/isa_pkg.sv
common/pipe_pkg.sv
verilog/wb_select.sv
alu/ma_unit.sv
alu/div_unit.sv
alu/cnvt_unit.sv
alu/srl_unit.sv
alu/alu.sv
testbench/tb_clock.sv
testbench/tb_alu.sv
